// ==== tb.f ====
+incdir+verilog
+incdir+dv
verilog/aes_pkg.sv
verilog/aes_sub_bytes.sv
verilog/aes_round.sv
verilog/aes_round_ctrl.sv
verilog/aes_core.sv
dv/tb_aes.sv

// ==== dv/aes_ref.svh ====
`ifndef AES_REF_SVH
`define AES_REF_SVH

// ----------------------------------------------------------------------------
// Reference model of the AES forward cipher over a given round-key set.
// ----------------------------------------------------------------------------
// The S-box is kept as one long vector, entry 00 in the top byte.
// Each literal is one row of the printed FIPS-197 table.
localparam logic [2047:0] REF_SBOX_BITS = {
	128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
	128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
	128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
	128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
	128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
	128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
	128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
	128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
};

function automatic logic [7:0] ref_sbox(input logic [7:0] b);
	return REF_SBOX_BITS[2047 - 8*int'(b) -: 8];
endfunction

// Multiply a byte by 1, 2 or 3 in GF(2^8), reducing by x^8 + x^4 + x^3 + x + 1.
function automatic logic [7:0] ref_gmul(input logic [7:0] a, input int m);
	logic [7:0] twice;
	twice = (a << 1) ^ (a[7] ? 8'h1b : 8'h00);
	if (m == 2)
		return twice;
	if (m == 3)
		return twice ^ a;
	return a;
endfunction

// Round count per key-size code. Code 3 runs as a 256-bit key.
function automatic int ref_rounds(input logic [1:0] key_size);
	case (key_size)
		2'd0:    return 10;
		2'd1:    return 12;
		default: return 14;
	endcase
endfunction

// The state is held as s[row][col]. AES byte 4*col+row sits at block index 15-4*col-row.
function automatic aes_pkg::block_t aes_ref_encrypt(
	input aes_pkg::block_t      plain,
	input aes_pkg::round_keys_t keys,
	input logic [1:0]           key_size
);
	logic [7:0] s [4][4];
	logic [7:0] t [4][4];
	aes_pkg::block_t result;
	int nr;
	nr = ref_rounds(key_size);
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			s[r][c] = plain[15 - 4*c - r] ^ keys[0][15 - 4*c - r];
		end
	end
	for (int rnd = 1; rnd <= nr; rnd++) begin
		// SubBytes and ShiftRows together: row r takes its bytes from r columns to the right.
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				t[r][c] = ref_sbox(s[r][(c + r) % 4]);
			end
		end
		// MixColumns is left out of the final round.
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				if (rnd == nr) begin
					s[r][c] = t[r][c];
				end else begin
					s[r][c] = ref_gmul(t[r][c], 2) ^ ref_gmul(t[(r + 1) % 4][c], 3)
						^ t[(r + 2) % 4][c] ^ t[(r + 3) % 4][c];
				end
				s[r][c] = s[r][c] ^ keys[rnd][15 - 4*c - r];
			end
		end
	end
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++) begin
			result[15 - 4*c - r] = s[r][c];
		end
	end
	return result;
endfunction

`endif

// ==== dv/tb_aes.sv ====
module tb_aes;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_PER_SIZE  = 2;
	localparam int N_RANDOM    = 8;
	localparam int N_CHAIN     = 4;
	// Directed sizes, random sizes, the busy test, the chain and the reset check.
	localparam int NUM_TESTS   = 4*N_PER_SIZE + N_RANDOM + 1 + N_CHAIN + 1;
	localparam int WATCHDOG_NS = NUM_TESTS*20*10 + 200;

	logic                 eph1 = 1'b0;
	logic                 rst_i;
	logic                 start_i;
	aes_pkg::key_size_t   key_size_i;
	aes_pkg::block_t      plain_i;
	aes_pkg::round_keys_t round_keys_i;
	logic                 busy_o;
	logic                 done_o;
	aes_pkg::block_t      cipher_o;

	logic [31:0] lfsr_q = 32'hed98;
	int          cycle_cnt = 0;
	string       current_test = "reset";

	// One entry per accepted start, oldest first.
	string           exp_name_q[$];
	int              exp_start_q[$];
	int              exp_done_q[$];
	aes_pkg::block_t exp_cipher_q[$];

	`include "aes_ref.svh"

	aes_core uut (
		.eph1         (eph1),
		.rst_i        (rst_i),
		.start_i      (start_i),
		.key_size_i   (key_size_i),
		.plain_i      (plain_i),
		.round_keys_i (round_keys_i),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.cipher_o     (cipher_o)
	);

	always #5 eph1 = ~eph1;

	// Counts rising edges. The checker reads it between edges.
	always @(posedge eph1) cycle_cnt <= cycle_cnt + 1;

	// ------------------------------------------------------------------------
	// Random numbers and input helpers.
	// ------------------------------------------------------------------------
	// Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Steps the LFSR once per bit, newest bit at the bottom.
	function automatic logic [127:0] take_bits(input int n);
		logic [127:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[126:0], lfsr_q[0]};
		end
		return v;
	endfunction

	task automatic randomize_inputs();
		logic [127:0] rnd;
		plain_i = take_bits(128);
		for (int i = 0; i <= 14; i++) begin
			round_keys_i[i] = take_bits(128);
		end
		rnd = take_bits(2);
		key_size_i = aes_pkg::key_size_t'(rnd[1:0]);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_block(input string name, input aes_pkg::block_t exp,
		input aes_pkg::block_t act);
		if (act !== exp) begin
			abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge eph1);
			#1;
		end
	endtask

	// Pulses start with the inputs now on the bus and records what must come back.
	// The inputs are scrambled right after, since the core has to hold its own copy.
	task automatic start_block(input string name);
		int nr;
		nr = ref_rounds(key_size_i);
		exp_name_q.push_back(name);
		exp_start_q.push_back(cycle_cnt + 1);
		exp_done_q.push_back(cycle_cnt + 1 + nr);
		exp_cipher_q.push_back(aes_ref_encrypt(plain_i, round_keys_i, key_size_i));
		start_i = 1'b1;
		@(posedge eph1);
		#1;
		start_i = 1'b0;
		randomize_inputs();
	endtask

	// Returns 1 ns into the done cycle. The watchdog bounds the wait.
	task automatic wait_done();
		do begin
			@(posedge eph1);
			#1;
		end while (!done_o);
	endtask

	// ------------------------------------------------------------------------
	// Checker.
	// ------------------------------------------------------------------------
	// Every falling edge after reset compares busy, done and the ciphertext
	// with what the queue of accepted starts predicts for this cycle.
	initial begin : check_outputs
		logic  exp_busy;
		logic  exp_done;
		string name;
		forever begin
			@(negedge eph1);
			if (!rst_i) begin
				exp_busy = 1'b0;
				foreach (exp_start_q[i]) begin
					if (exp_start_q[i] <= cycle_cnt && cycle_cnt < exp_done_q[i])
						exp_busy = 1'b1;
				end
				exp_done = (exp_done_q.size() > 0) && (exp_done_q[0] == cycle_cnt);
				name = exp_done ? exp_name_q[0] : current_test;
				check_bit({name, " busy_o"}, exp_busy, busy_o);
				check_bit({name, " done_o"}, exp_done, done_o);
				if (exp_done) begin
					check_block({name, " cipher_o"}, exp_cipher_q[0], cipher_o);
					void'(exp_name_q.pop_front());
					void'(exp_start_q.pop_front());
					void'(exp_done_q.pop_front());
					void'(exp_cipher_q.pop_front());
				end else begin
					check_block({name, " cipher_o"}, '0, cipher_o);
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		abort_run("Timeout: done_o never arrived for a started block.");
	end

	// ------------------------------------------------------------------------
	// Stimulus.
	// ------------------------------------------------------------------------
	initial begin : stimulus
		rst_i        = 1'b1;
		start_i      = 1'b0;
		key_size_i   = aes_pkg::KEY_128;
		plain_i      = '0;
		round_keys_i = '0;
		// A start during reset must leave the core idle.
		@(posedge eph1);
		#1;
		start_i = 1'b1;
		@(posedge eph1);
		#1;
		start_i = 1'b0;
		rst_i   = 1'b0;
		idle_cycles(3);

		// Every key-size code, code 3 included.
		for (int ks = 0; ks < 4; ks++) begin
			for (int n = 0; n < N_PER_SIZE; n++) begin
				current_test = $sformatf("size%0d_%0d", ks, n);
				randomize_inputs();
				key_size_i = aes_pkg::key_size_t'(ks);
				start_block(current_test);
				wait_done();
				idle_cycles(2);
			end
		end

		for (int n = 0; n < N_RANDOM; n++) begin
			current_test = $sformatf("random_%0d", n);
			randomize_inputs();
			start_block(current_test);
			wait_done();
			idle_cycles(1);
		end

		// A second start while busy is dropped, new inputs and all.
		current_test = "busy_start";
		randomize_inputs();
		start_block(current_test);
		idle_cycles(3);
		randomize_inputs();
		start_i = 1'b1;
		@(posedge eph1);
		#1;
		start_i = 1'b0;
		wait_done();
		idle_cycles(2);

		// Each new block starts in the done cycle of the one before.
		current_test = "chain_0";
		randomize_inputs();
		start_block(current_test);
		for (int n = 1; n < N_CHAIN; n++) begin
			wait_done();
			current_test = $sformatf("chain_%0d", n);
			randomize_inputs();
			start_block(current_test);
		end
		wait_done();
		current_test = "end";
		idle_cycles(3);

		if (exp_done_q.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abort_run("Some accepted starts never produced done_o.");
		end
	end

endmodule

// ==== verilog/aes_core.sv ====
module aes_core (
	input  logic                 eph1,
	input  logic                 rst_i,
	input  logic                 start_i,
	input  aes_pkg::key_size_t   key_size_i,
	input  aes_pkg::block_t      plain_i,
	input  aes_pkg::round_keys_t round_keys_i,
	output logic                 busy_o,
	output logic                 done_o,
	output aes_pkg::block_t      cipher_o
);

	logic                 load_w;
	logic                 last_round_w;
	aes_pkg::round_idx_t  round_idx_w;
	aes_pkg::round_keys_t round_keys_q;
	aes_pkg::block_t      state_q;
	aes_pkg::block_t      round_key_w;
	aes_pkg::block_t      next_state_w;

	// --------------------------------------------------------------------------
	// Control.
	// --------------------------------------------------------------------------
	aes_round_ctrl u_ctrl (
		.eph1         (eph1),
		.rst_i        (rst_i),
		.start_i      (start_i),
		.key_size_i   (key_size_i),
		.load_o       (load_w),
		.busy_o       (busy_o),
		.round_idx_o  (round_idx_w),
		.last_round_o (last_round_w),
		.done_o       (done_o)
	);

	// --------------------------------------------------------------------------
	// Datapath.
	// --------------------------------------------------------------------------
	// Key for the round being computed this cycle.
	assign round_key_w = round_keys_q[round_idx_w];

	aes_round u_round (
		.state_i      (state_q),
		.round_key_i  (round_key_w),
		.last_round_i (last_round_w),
		.state_o      (next_state_w)
	);

	// The caller's inputs are only valid in the start cycle, so the key set
	// is copied here. The whitening XOR with key 0 happens on the way in.
	// Each busy cycle then replaces the state with one more round.
	always_ff @(posedge eph1) begin
		if (load_w) begin
			round_keys_q <= round_keys_i;
			state_q      <= plain_i ^ round_keys_i[0];
		end else if (busy_o) begin
			state_q <= next_state_w;
		end
	end

	// The finished block is shown only while done is high.
	assign cipher_o = done_o ? state_q : '0;

	// Outside a load or a running block the state must hold.
	a_state_hold: assert property (@(posedge eph1) disable iff (rst_i)
		!(load_w || busy_o) |=> (state_q === $past(state_q)));

endmodule

// ==== verilog/aes_round_ctrl.sv ====
`include "aes_cfg.svh"

module aes_round_ctrl (
	input  logic                eph1,
	input  logic                rst_i,
	input  logic                start_i,
	input  aes_pkg::key_size_t  key_size_i,
	output logic                load_o,
	output logic                busy_o,
	output aes_pkg::round_idx_t round_idx_o,
	output logic                last_round_o,
	output logic                done_o
);

	aes_pkg::key_size_t  key_size_q;
	aes_pkg::round_idx_t round_idx_q;
	aes_pkg::round_idx_t num_rounds_w;
	logic                busy_q;
	logic                done_q;

	// Round count for the captured key size. Both 256-bit codes land in
	// the default arm.
	always_comb begin
		case (key_size_q)
			aes_pkg::KEY_128: num_rounds_w = aes_pkg::round_idx_t'(`AES_ROUNDS_128);
			aes_pkg::KEY_192: num_rounds_w = aes_pkg::round_idx_t'(`AES_ROUNDS_192);
			default:          num_rounds_w = aes_pkg::round_idx_t'(`AES_ROUNDS_256);
		endcase
	end

	// A start is taken only while idle. Anything arriving mid-block is dropped.
	assign load_o = start_i && !busy_q;

	// The last round skips MixColumns and ends the block.
	assign last_round_o = busy_q && (round_idx_q == num_rounds_w);

	// --------------------------------------------------------------------------
	// Round sequencing.
	// --------------------------------------------------------------------------
	// After an accepted start the index runs 1..Nr, one round per edge.
	// Busy drops at the same edge that raises done, so the done cycle is
	// already idle and can take the next start.
	always_ff @(posedge eph1) begin
		if (rst_i) begin
			busy_q      <= 1'b0;
			done_q      <= 1'b0;
			round_idx_q <= '0;
			key_size_q  <= aes_pkg::KEY_128;
		end else begin
			done_q <= last_round_o;
			if (load_o) begin
				busy_q      <= 1'b1;
				round_idx_q <= aes_pkg::round_idx_t'(1);
				key_size_q  <= key_size_i;
			end else if (last_round_o) begin
				busy_q      <= 1'b0;
				round_idx_q <= '0;
			end else if (busy_q) begin
				round_idx_q <= round_idx_q + aes_pkg::round_idx_t'(1);
			end
		end
	end

	assign busy_o      = busy_q;
	assign done_o      = done_q;
	assign round_idx_o = round_idx_q;

	// The index must stay within the round-key set in the core.
	a_idx_range: assert property (@(posedge eph1) disable iff (rst_i)
		round_idx_q <= `AES_MAX_ROUNDS);

	// Done is a single-cycle strobe.
	a_done_pulse: assert property (@(posedge eph1) disable iff (rst_i)
		done_q |=> !done_q);

	// Loading while busy would corrupt the block in flight.
	a_load_idle: assert property (@(posedge eph1) disable iff (rst_i)
		load_o |-> !busy_o);

endmodule

// ==== verilog/aes_round.sv ====
module aes_round (
	input  aes_pkg::block_t state_i,
	input  aes_pkg::block_t round_key_i,
	input  logic            last_round_i,
	output aes_pkg::block_t state_o
);

	aes_pkg::block_t sub_w;
	aes_pkg::block_t shift_w;
	aes_pkg::block_t mix_w;

	// --------------------------------------------------------------------------
	// SubBytes.
	// --------------------------------------------------------------------------
	aes_sub_bytes u_sub_bytes (
		.data_i (state_i),
		.data_o (sub_w)
	);

	// --------------------------------------------------------------------------
	// ShiftRows.
	// --------------------------------------------------------------------------
	// State byte (row r, column c) is AES byte 4c+r, which lives at packed
	// index 15-4c-r. Row r rotates left by r, so the output at column c
	// takes the input from column (c+r) mod 4 of the same row.
	// Row 0 passes straight through.
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shift_w[15 - 4*c - r] = sub_w[15 - 4*((c + r) % 4) - r];
			end
		end
	end

	// --------------------------------------------------------------------------
	// MixColumns.
	// --------------------------------------------------------------------------
	// Each column is multiplied by the circulant matrix
	//   | 2 3 1 1 |
	//   | 1 2 3 1 |
	//   | 1 1 2 3 |
	//   | 3 1 1 2 |
	// over GF(2^8). Addition is XOR and 3a is written as 2a ^ a.
	always_comb begin
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		for (int c = 0; c < 4; c++) begin
			// Rows 0..3 of this column, top row at the highest index.
			a0 = shift_w[15 - 4*c];
			a1 = shift_w[14 - 4*c];
			a2 = shift_w[13 - 4*c];
			a3 = shift_w[12 - 4*c];
			mix_w[15 - 4*c] = aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3;
			mix_w[14 - 4*c] = a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3;
			mix_w[13 - 4*c] = a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3;
			mix_w[12 - 4*c] = aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3);
		end
	end

	// --------------------------------------------------------------------------
	// AddRoundKey.
	// --------------------------------------------------------------------------
	// The final round of the cipher has no MixColumns step.
	// The key is laid out in the same byte order as the state, so a plain
	// vector XOR lines every key byte up with its state byte.
	assign state_o = (last_round_i ? shift_w : mix_w) ^ round_key_i;

endmodule

// ==== verilog/aes_sub_bytes.sv ====
`include "aes_cfg.svh"

module aes_sub_bytes (
	input  aes_pkg::block_t data_i,
	output aes_pkg::block_t data_o
);

	// --------------------------------------------------------------------------
	// Forward Rijndael S-box.
	// --------------------------------------------------------------------------
	// The ascending packed range puts entry 00 at the left, so each literal
	// below is one row of the usual printed table (high nibble selects the row).
	// Input 00 maps to 63 and input ff maps to 16.
	localparam logic [0:255][7:0] SBOX = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// Every byte of the state is substituted independently.
	// The position of a byte within the block does not matter here,
	// so the loop simply walks the packed byte index.
	always_comb begin
		for (int i = 0; i < `AES_BLOCK_BYTES; i++) begin
			data_o[i] = SBOX[data_i[i]];
		end
	end

endmodule

// ==== verilog/aes_pkg.sv ====
`include "aes_cfg.svh"

package aes_pkg;

	// One 128-bit block. Byte 15 sits in bits 127:120 and is AES state byte 0.
	// The state fills column by column, so bytes 15..12 are the first column.
	typedef logic [`AES_BLOCK_BYTES-1:0][7:0] block_t;

	// Key-size code from the caller. Code 3 runs like a 256-bit key.
	typedef enum logic [1:0] {
		KEY_128  = 2'd0,
		KEY_192  = 2'd1,
		KEY_256  = 2'd2,
		KEY_256X = 2'd3
	} key_size_t;

	// Round index, 0 to 14.
	typedef logic [3:0] round_idx_t;

	// Expanded round keys. Index 0 is the whitening key, index r feeds round r.
	typedef block_t [`AES_MAX_ROUNDS:0] round_keys_t;

	// Multiply by 2 in GF(2^8).
	// A carry out of bit 7 folds back in through the reduction constant.
	function automatic logic [7:0] xtime(input logic [7:0] b);
		logic [7:0] shifted;
		shifted = {b[6:0], 1'b0};
		return b[7] ? (shifted ^ `AES_MIX_POLY) : shifted;
	endfunction

endpackage

// ==== verilog/aes_cfg.svh ====
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// Bytes in one AES block, the state is 4 rows by 4 columns.
`define AES_BLOCK_BYTES 16

// Round counts per key size, as given by FIPS-197.
`define AES_ROUNDS_128 10
`define AES_ROUNDS_192 12
`define AES_ROUNDS_256 14

// Largest round count. The round-key set holds one more key than this
// because of the initial whitening key.
`define AES_MAX_ROUNDS 14

// Low byte of the field polynomial x^8 + x^4 + x^3 + x + 1.
`define AES_MIX_POLY 8'h1b

`endif
